//--- logic/lrsc_macros.svh
// LR/SC adapter widths and codes
`ifndef LRSC_MACROS_SVH
`define LRSC_MACROS_SVH

`define LRSC_ADDR_WIDTH 32
`define LRSC_DATA_WIDTH 32
`define LRSC_ID_WIDTH   2
`define LRSC_STRB_WIDTH (`LRSC_DATA_WIDTH / 8)

// Exclusive range, closed interval of word addresses
`define LRSC_RES_BEGIN 32'h0000_1000
`define LRSC_RES_END   32'h0000_1FFC

// AXI response codes
`define LRSC_RESP_OKAY   2'b00
`define LRSC_RESP_EXOKAY 2'b01
`define LRSC_RESP_SLVERR 2'b10

`endif

//--- logic/lrsc_axi_pkg.sv
// AXI-style channel types
`include "lrsc_macros.svh"

package lrsc_axi_pkg;

    typedef logic [`LRSC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LRSC_DATA_WIDTH-1:0] data_t;
    typedef logic [`LRSC_STRB_WIDTH-1:0] strb_t;
    typedef logic [`LRSC_ID_WIDTH-1:0]   id_t;
    typedef logic [1:0]                  resp_t;

    // Shared by AR and AW
    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } ax_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        resp_t resp;
    } r_chan_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

endpackage

//--- logic/lrsc_res_pkg.sv
// Reservation table types
`include "lrsc_macros.svh"

package lrsc_res_pkg;

    // Reservations are tracked per 32-bit word
    typedef logic [`LRSC_ADDR_WIDTH-3:0] res_addr_t;

    typedef struct packed {
        logic      valid;
        res_addr_t addr;
    } res_entry_t;

    // Origin of the pending write response
    typedef enum logic [1:0] {
        B_REGULAR   = 2'd0,
        B_EXCLUSIVE = 2'd1,
        B_INJECT    = 2'd2
    } b_src_t;

endpackage

//--- logic/lrsc_resp_reg.sv
// Response pipeline register
module lrsc_resp_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     full_q;
    payload_t data_q;

    // Slot is free when empty or when the held entry leaves this cycle
    assign ready_o = !full_q || ready_i;
    assign valid_o = full_q;
    assign data_o  = data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

endmodule

//--- logic/lrsc_res_table.sv
// Per-ID reservation table
module lrsc_res_table (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      res_set_i,
    input  lrsc_axi_pkg::id_t         res_set_id_i,
    input  lrsc_res_pkg::res_addr_t   res_set_addr_i,
    input  lrsc_axi_pkg::id_t         res_chk_id_i,
    input  lrsc_res_pkg::res_addr_t   res_chk_addr_i,
    output logic                      res_hit_o,
    input  logic                      res_clr_i,
    input  logic                      res_clr_excl_i
);

    localparam int unsigned NUM_IDS = 2 ** $bits(lrsc_axi_pkg::id_t);

    lrsc_res_pkg::res_entry_t entries_q [NUM_IDS];
    lrsc_res_pkg::res_entry_t entries_d [NUM_IDS];

    assign res_hit_o = entries_q[res_chk_id_i].valid &&
                       (entries_q[res_chk_id_i].addr == res_chk_addr_i);

    always_comb begin
        entries_d = entries_q;
        // Clear goes first so that a set in the same cycle survives
        if (res_clr_i) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                if (entries_q[i].addr == res_chk_addr_i) begin
                    entries_d[i].valid = 1'b0;
                end
            end
            if (res_clr_excl_i) begin
                entries_d[res_chk_id_i].valid = 1'b0;
            end
        end
        if (res_set_i) begin
            entries_d[res_set_id_i].valid = 1'b1;
            entries_d[res_set_id_i].addr  = res_set_addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            entries_q <= entries_d;
        end
    end

endmodule

//--- logic/lrsc_read_path.sv
// LR/SC read path
`include "lrsc_macros.svh"

module lrsc_read_path (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  lrsc_axi_pkg::ax_chan_t    slv_ar_i,
    input  logic                      slv_ar_valid_i,
    output logic                      slv_ar_ready_o,
    output lrsc_axi_pkg::ax_chan_t    mst_ar_o,
    output logic                      mst_ar_valid_o,
    input  logic                      mst_ar_ready_i,
    input  lrsc_axi_pkg::r_chan_t     mst_r_i,
    input  logic                      mst_r_valid_i,
    output logic                      mst_r_ready_o,
    output lrsc_axi_pkg::r_chan_t     r_o,
    output logic                      r_valid_o,
    input  logic                      r_ready_i,
    output logic                      res_set_o,
    output lrsc_axi_pkg::id_t         res_set_id_o,
    output lrsc_res_pkg::res_addr_t   res_set_addr_o
);

    logic busy_q;
    logic excl_q;
    logic ar_excl;
    logic ar_fire;
    logic r_fire;

    assign ar_excl = slv_ar_i.lock &&
                     (slv_ar_i.addr >= `LRSC_RES_BEGIN) && (slv_ar_i.addr <= `LRSC_RES_END);

    // Only one read in flight so AR stalls while busy
    assign mst_ar_valid_o = slv_ar_valid_i && !busy_q;
    assign slv_ar_ready_o = mst_ar_ready_i && !busy_q;
    assign ar_fire        = mst_ar_valid_o && mst_ar_ready_i;

    always_comb begin
        mst_ar_o      = slv_ar_i;
        mst_ar_o.lock = 1'b0;
    end

    assign res_set_o      = ar_fire && ar_excl;
    assign res_set_id_o   = slv_ar_i.id;
    assign res_set_addr_o = slv_ar_i.addr[`LRSC_ADDR_WIDTH-1:2];

    assign r_valid_o     = mst_r_valid_i && busy_q;
    assign mst_r_ready_o = r_ready_i && busy_q;
    assign r_fire        = r_valid_o && r_ready_i;

    // Only a successful exclusive read becomes EXOKAY
    always_comb begin
        r_o = mst_r_i;
        if (excl_q && (mst_r_i.resp == `LRSC_RESP_OKAY)) begin
            r_o.resp = `LRSC_RESP_EXOKAY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            excl_q <= 1'b0;
        end else if (ar_fire) begin
            busy_q <= 1'b1;
            excl_q <= ar_excl;
        end else if (r_fire) begin
            busy_q <= 1'b0;
        end
    end

endmodule

//--- logic/lrsc_write_path.sv
// LR/SC write path
`include "lrsc_macros.svh"

module lrsc_write_path (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  lrsc_axi_pkg::ax_chan_t    slv_aw_i,
    input  logic                      slv_aw_valid_i,
    output logic                      slv_aw_ready_o,
    input  lrsc_axi_pkg::w_chan_t     slv_w_i,
    input  logic                      slv_w_valid_i,
    output logic                      slv_w_ready_o,
    output lrsc_axi_pkg::ax_chan_t    mst_aw_o,
    output logic                      mst_aw_valid_o,
    input  logic                      mst_aw_ready_i,
    output lrsc_axi_pkg::w_chan_t     mst_w_o,
    output logic                      mst_w_valid_o,
    input  logic                      mst_w_ready_i,
    input  lrsc_axi_pkg::b_chan_t     mst_b_i,
    input  logic                      mst_b_valid_i,
    output logic                      mst_b_ready_o,
    output lrsc_axi_pkg::b_chan_t     b_o,
    output logic                      b_valid_o,
    input  logic                      b_ready_i,
    output lrsc_axi_pkg::id_t         res_chk_id_o,
    output lrsc_res_pkg::res_addr_t   res_chk_addr_o,
    input  logic                      res_hit_i,
    output logic                      res_clr_o,
    output logic                      res_clr_excl_o
);

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t              state_q;
    wr_state_t              state_d;
    lrsc_res_pkg::b_src_t   src_q;
    lrsc_res_pkg::b_src_t   aw_src;
    lrsc_axi_pkg::id_t      id_q;
    logic                   aw_in_range;
    logic                   aw_excl;
    logic                   aw_fire;

    assign aw_in_range = (slv_aw_i.addr >= `LRSC_RES_BEGIN) &&
                         (slv_aw_i.addr <= `LRSC_RES_END);
    assign aw_excl     = slv_aw_i.lock && aw_in_range;

    // An exclusive write without a matching reservation is dropped
    assign aw_src = !aw_excl ? lrsc_res_pkg::B_REGULAR :
                    res_hit_i ? lrsc_res_pkg::B_EXCLUSIVE : lrsc_res_pkg::B_INJECT;

    assign res_chk_id_o   = slv_aw_i.id;
    assign res_chk_addr_o = slv_aw_i.addr[`LRSC_ADDR_WIDTH-1:2];
    assign aw_fire        = slv_aw_valid_i && slv_aw_ready_o;
    assign res_clr_o      = aw_fire && aw_in_range;
    assign res_clr_excl_o = aw_excl;

    always_comb begin
        mst_aw_o      = slv_aw_i;
        mst_aw_o.lock = 1'b0;
    end

    assign mst_w_o = slv_w_i;

    always_comb begin
        state_d        = state_q;
        slv_aw_ready_o = 1'b0;
        mst_aw_valid_o = 1'b0;
        slv_w_ready_o  = 1'b0;
        mst_w_valid_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        b_valid_o      = 1'b0;
        b_o.id         = id_q;
        b_o.resp       = `LRSC_RESP_OKAY;
        case (state_q)
            WR_ADDR: begin
                if (aw_src == lrsc_res_pkg::B_INJECT) begin
                    slv_aw_ready_o = 1'b1;
                end else begin
                    mst_aw_valid_o = slv_aw_valid_i;
                    slv_aw_ready_o = mst_aw_ready_i;
                end
                if (aw_fire) begin
                    state_d = WR_DATA;
                end
            end
            WR_DATA: begin
                if (src_q == lrsc_res_pkg::B_INJECT) begin
                    // Dropped data is answered right away with OKAY
                    b_valid_o     = slv_w_valid_i;
                    slv_w_ready_o = b_ready_i;
                    if (slv_w_valid_i && b_ready_i) begin
                        state_d = WR_ADDR;
                    end
                end else begin
                    mst_w_valid_o = slv_w_valid_i;
                    slv_w_ready_o = mst_w_ready_i;
                    if (slv_w_valid_i && mst_w_ready_i) begin
                        state_d = WR_RESP;
                    end
                end
            end
            WR_RESP: begin
                b_valid_o     = mst_b_valid_i;
                mst_b_ready_o = b_ready_i;
                b_o.id        = mst_b_i.id;
                if (mst_b_i.resp[1]) begin
                    b_o.resp = mst_b_i.resp;
                end else if (src_q == lrsc_res_pkg::B_EXCLUSIVE) begin
                    b_o.resp = `LRSC_RESP_EXOKAY;
                end
                if (mst_b_valid_i && b_ready_i) begin
                    state_d = WR_ADDR;
                end
            end
            default: begin
                state_d = WR_ADDR;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= WR_ADDR;
            src_q   <= lrsc_res_pkg::B_REGULAR;
        end else begin
            state_q <= state_d;
            if (aw_fire) begin
                src_q <= aw_src;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            id_q <= slv_aw_i.id;
        end
    end

endmodule

//--- logic/axi_lrsc.sv
// LR/SC adapter top level
module axi_lrsc (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // Upstream side
    input  lrsc_axi_pkg::ax_chan_t    slv_ar_i,
    input  logic                      slv_ar_valid_i,
    output logic                      slv_ar_ready_o,
    input  lrsc_axi_pkg::ax_chan_t    slv_aw_i,
    input  logic                      slv_aw_valid_i,
    output logic                      slv_aw_ready_o,
    input  lrsc_axi_pkg::w_chan_t     slv_w_i,
    input  logic                      slv_w_valid_i,
    output logic                      slv_w_ready_o,
    output lrsc_axi_pkg::r_chan_t     slv_r_o,
    output logic                      slv_r_valid_o,
    input  logic                      slv_r_ready_i,
    output lrsc_axi_pkg::b_chan_t     slv_b_o,
    output logic                      slv_b_valid_o,
    input  logic                      slv_b_ready_i,
    // Slave side
    output lrsc_axi_pkg::ax_chan_t    mst_ar_o,
    output logic                      mst_ar_valid_o,
    input  logic                      mst_ar_ready_i,
    output lrsc_axi_pkg::ax_chan_t    mst_aw_o,
    output logic                      mst_aw_valid_o,
    input  logic                      mst_aw_ready_i,
    output lrsc_axi_pkg::w_chan_t     mst_w_o,
    output logic                      mst_w_valid_o,
    input  logic                      mst_w_ready_i,
    input  lrsc_axi_pkg::r_chan_t     mst_r_i,
    input  logic                      mst_r_valid_i,
    output logic                      mst_r_ready_o,
    input  lrsc_axi_pkg::b_chan_t     mst_b_i,
    input  logic                      mst_b_valid_i,
    output logic                      mst_b_ready_o
);

    lrsc_axi_pkg::r_chan_t      r_path;
    logic                       r_path_valid;
    logic                       r_path_ready;
    lrsc_axi_pkg::b_chan_t      b_path;
    logic                       b_path_valid;
    logic                       b_path_ready;
    logic                       res_set;
    lrsc_axi_pkg::id_t          res_set_id;
    lrsc_res_pkg::res_addr_t    res_set_addr;
    lrsc_axi_pkg::id_t          res_chk_id;
    lrsc_res_pkg::res_addr_t    res_chk_addr;
    logic                       res_hit;
    logic                       res_clr;
    logic                       res_clr_excl;

    lrsc_read_path i_read_path (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_ar_i       (slv_ar_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .mst_ar_o       (mst_ar_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_ready_i (mst_ar_ready_i),
        .mst_r_i        (mst_r_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .r_o            (r_path),
        .r_valid_o      (r_path_valid),
        .r_ready_i      (r_path_ready),
        .res_set_o      (res_set),
        .res_set_id_o   (res_set_id),
        .res_set_addr_o (res_set_addr)
    );

    lrsc_write_path i_write_path (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_aw_i       (slv_aw_i),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .slv_w_i        (slv_w_i),
        .slv_w_valid_i  (slv_w_valid_i),
        .slv_w_ready_o  (slv_w_ready_o),
        .mst_aw_o       (mst_aw_o),
        .mst_aw_valid_o (mst_aw_valid_o),
        .mst_aw_ready_i (mst_aw_ready_i),
        .mst_w_o        (mst_w_o),
        .mst_w_valid_o  (mst_w_valid_o),
        .mst_w_ready_i  (mst_w_ready_i),
        .mst_b_i        (mst_b_i),
        .mst_b_valid_i  (mst_b_valid_i),
        .mst_b_ready_o  (mst_b_ready_o),
        .b_o            (b_path),
        .b_valid_o      (b_path_valid),
        .b_ready_i      (b_path_ready),
        .res_chk_id_o   (res_chk_id),
        .res_chk_addr_o (res_chk_addr),
        .res_hit_i      (res_hit),
        .res_clr_o      (res_clr),
        .res_clr_excl_o (res_clr_excl)
    );

    lrsc_res_table i_res_table (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .res_set_i      (res_set),
        .res_set_id_i   (res_set_id),
        .res_set_addr_i (res_set_addr),
        .res_chk_id_i   (res_chk_id),
        .res_chk_addr_i (res_chk_addr),
        .res_hit_o      (res_hit),
        .res_clr_i      (res_clr),
        .res_clr_excl_i (res_clr_excl)
    );

    lrsc_resp_reg #(
        .payload_t (lrsc_axi_pkg::r_chan_t)
    ) i_r_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (r_path_valid),
        .ready_o (r_path_ready),
        .data_i  (r_path),
        .valid_o (slv_r_valid_o),
        .ready_i (slv_r_ready_i),
        .data_o  (slv_r_o)
    );

    lrsc_resp_reg #(
        .payload_t (lrsc_axi_pkg::b_chan_t)
    ) i_b_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (b_path_valid),
        .ready_o (b_path_ready),
        .data_i  (b_path),
        .valid_o (slv_b_valid_o),
        .ready_i (slv_b_ready_i),
        .data_o  (slv_b_o)
    );

endmodule

//--- tb/tb_clk_gen.sv
// Testbench clock and reset
module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 8,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Release just after an edge so the first cycle starts clean
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

//--- tb/tb_axi_lrsc.sv
// LR/SC adapter testbench
`include "lrsc_macros.svh"

module tb_axi_lrsc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] DATA_PATTERN = 32'hA5A5_A5A5;
    localparam logic [31:0] SLVERR_ADDR  = 32'h0000_1F00;
    localparam int unsigned RAND_SEED    = 32'hf955_8d5e;
    localparam int          NUM_TESTS    = 6;
    localparam int          TEST_CYCLES  = 300;
    // Six tests plus reset and some slack
    localparam int          MAX_CYCLES   = NUM_TESTS * TEST_CYCLES + 200;

    logic clk;
    logic rst_n;

    lrsc_axi_pkg::ax_chan_t slv_ar, slv_aw, mst_ar, mst_aw;
    lrsc_axi_pkg::w_chan_t  slv_w, mst_w;
    lrsc_axi_pkg::r_chan_t  slv_r, mst_r;
    lrsc_axi_pkg::b_chan_t  slv_b, mst_b;
    logic slv_ar_valid, slv_ar_ready, slv_aw_valid, slv_aw_ready;
    logic slv_w_valid, slv_w_ready, slv_r_valid, slv_r_ready;
    logic slv_b_valid, slv_b_ready;
    logic mst_ar_valid, mst_ar_ready, mst_aw_valid, mst_aw_ready;
    logic mst_w_valid, mst_w_ready, mst_r_valid, mst_r_ready;
    logic mst_b_valid, mst_b_ready;

    // Expected responses in request order
    lrsc_axi_pkg::r_chan_t  exp_r[$];
    lrsc_axi_pkg::b_chan_t  exp_b[$];
    lrsc_axi_pkg::r_chan_t  r_exp;
    lrsc_axi_pkg::b_chan_t  b_exp;
    lrsc_axi_pkg::ax_chan_t slave_ar, slave_aw;

    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycles;
    int          aw_count;
    int          w_count;
    int          aw_before;
    int          w_before;
    logic [31:0] last_w_data;
    logic [3:0]  last_w_strb;
    logic        stall_ready;
    string       test_name;

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (16)
    ) i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    axi_lrsc UUT (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .slv_ar_i       (slv_ar),
        .slv_ar_valid_i (slv_ar_valid),
        .slv_ar_ready_o (slv_ar_ready),
        .slv_aw_i       (slv_aw),
        .slv_aw_valid_i (slv_aw_valid),
        .slv_aw_ready_o (slv_aw_ready),
        .slv_w_i        (slv_w),
        .slv_w_valid_i  (slv_w_valid),
        .slv_w_ready_o  (slv_w_ready),
        .slv_r_o        (slv_r),
        .slv_r_valid_o  (slv_r_valid),
        .slv_r_ready_i  (slv_r_ready),
        .slv_b_o        (slv_b),
        .slv_b_valid_o  (slv_b_valid),
        .slv_b_ready_i  (slv_b_ready),
        .mst_ar_o       (mst_ar),
        .mst_ar_valid_o (mst_ar_valid),
        .mst_ar_ready_i (mst_ar_ready),
        .mst_aw_o       (mst_aw),
        .mst_aw_valid_o (mst_aw_valid),
        .mst_aw_ready_i (mst_aw_ready),
        .mst_w_o        (mst_w),
        .mst_w_valid_o  (mst_w_valid),
        .mst_w_ready_i  (mst_w_ready),
        .mst_r_i        (mst_r),
        .mst_r_valid_i  (mst_r_valid),
        .mst_r_ready_o  (mst_r_ready),
        .mst_b_i        (mst_b),
        .mst_b_valid_i  (mst_b_valid),
        .mst_b_ready_o  (mst_b_ready)
    );

    ar_lock_zero: assert property (@(posedge clk) disable iff (!rst_n)
        mst_ar_valid |-> !mst_ar.lock)
        else begin
            $display("Fail mst_ar_o.lock: got 0x%h expected 0x0", mst_ar.lock);
            errors++;
        end

    aw_lock_zero: assert property (@(posedge clk) disable iff (!rst_n)
        mst_aw_valid |-> !mst_aw.lock)
        else begin
            $display("Fail mst_aw_o.lock: got 0x%h expected 0x0", mst_aw.lock);
            errors++;
        end

    r_held: assert property (@(posedge clk) disable iff (!rst_n)
        slv_r_valid && !slv_r_ready |=> slv_r_valid && $stable(slv_r))
        else begin
            $display("R response changed or vanished before it was accepted");
            errors++;
        end

    b_held: assert property (@(posedge clk) disable iff (!rst_n)
        slv_b_valid && !slv_b_ready |=> slv_b_valid && $stable(slv_b))
        else begin
            $display("B response changed or vanished before it was accepted");
            errors++;
        end

    function automatic logic [1:0] slave_resp(input logic [31:0] addr);
        return (addr == SLVERR_ADDR) ? `LRSC_RESP_SLVERR : `LRSC_RESP_OKAY;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        value_match: assert (got === exp)
            else begin
                $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
                errors++;
            end
    endtask

    task automatic send_read(input logic [31:0] addr, input logic [1:0] id,
                             input logic lock, input logic [1:0] resp);
        lrsc_axi_pkg::r_chan_t exp;
        exp.data = addr ^ DATA_PATTERN;
        exp.id   = id;
        exp.resp = resp;
        exp_r.push_back(exp);
        slv_ar.addr  = addr;
        slv_ar.id    = id;
        slv_ar.lock  = lock;
        slv_ar_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!slv_ar_ready);
        @(posedge clk);
        #1;
        slv_ar_valid = 1'b0;
    endtask

    task automatic send_write(input logic [31:0] addr, input logic [1:0] id, input logic lock,
                              input logic [31:0] data, input logic [1:0] resp);
        lrsc_axi_pkg::b_chan_t exp;
        exp.id   = id;
        exp.resp = resp;
        exp_b.push_back(exp);
        slv_aw.addr  = addr;
        slv_aw.id    = id;
        slv_aw.lock  = lock;
        slv_aw_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!slv_aw_ready);
        @(posedge clk);
        #1;
        slv_aw_valid = 1'b0;
        slv_w.data   = data;
        slv_w.strb   = 4'hF;
        slv_w_valid  = 1'b1;
        do begin
            @(negedge clk);
        end while (!slv_w_ready);
        @(posedge clk);
        #1;
        slv_w_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_r.size() != 0 || exp_b.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
        aw_before   = aw_count;
        w_before    = w_count;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Slave read side answers one R per AR
    initial begin
        mst_r       = '0;
        mst_r_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (mst_ar_valid && mst_ar_ready) begin
                slave_ar = mst_ar;
                @(posedge clk);
                #1;
                mst_r.data  = slave_ar.addr ^ DATA_PATTERN;
                mst_r.id    = slave_ar.id;
                mst_r.resp  = slave_resp(slave_ar.addr);
                mst_r_valid = 1'b1;
                do begin
                    @(negedge clk);
                end while (!mst_r_ready);
                @(posedge clk);
                #1;
                mst_r_valid = 1'b0;
            end
        end
    end

    // Slave write side returns B after the W beat
    initial begin
        mst_b       = '0;
        mst_b_valid = 1'b0;
        aw_count    = 0;
        w_count     = 0;
        forever begin
            @(negedge clk);
            if (mst_aw_valid && mst_aw_ready) begin
                slave_aw = mst_aw;
                aw_count++;
            end
            if (mst_w_valid && mst_w_ready) begin
                last_w_data = mst_w.data;
                last_w_strb = mst_w.strb;
                w_count++;
                @(posedge clk);
                #1;
                mst_b.id    = slave_aw.id;
                mst_b.resp  = slave_resp(slave_aw.addr);
                mst_b_valid = 1'b1;
                do begin
                    @(negedge clk);
                end while (!mst_b_ready);
                @(posedge clk);
                #1;
                mst_b_valid = 1'b0;
            end
        end
    end

    // Upstream ready is randomly stalled in the back-pressure test
    initial begin
        void'($urandom(RAND_SEED));
        slv_r_ready = 1'b1;
        slv_b_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            slv_r_ready = !stall_ready || (($urandom % 4) != 0);
            slv_b_ready = !stall_ready || (($urandom % 3) != 0);
        end
    end

    // Response scoreboard
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && slv_r_valid && slv_r_ready) begin
                r_expected: assert (exp_r.size() != 0)
                    else begin
                        $display("R response with id 0x%h arrived unrequested", slv_r.id);
                        errors++;
                    end
                if (exp_r.size() != 0) begin
                    r_exp = exp_r.pop_front();
                    check_value("slv_r_o.id", slv_r.id, r_exp.id);
                    check_value("slv_r_o.data", slv_r.data, r_exp.data);
                    check_value("slv_r_o.resp", slv_r.resp, r_exp.resp);
                end
            end
            if (rst_n && slv_b_valid && slv_b_ready) begin
                b_expected: assert (exp_b.size() != 0)
                    else begin
                        $display("B response with id 0x%h arrived unrequested", slv_b.id);
                        errors++;
                    end
                if (exp_b.size() != 0) begin
                    b_exp = exp_b.pop_front();
                    check_value("slv_b_o.id", slv_b.id, b_exp.id);
                    check_value("slv_b_o.resp", slv_b.resp, b_exp.resp);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        stall_ready  = 1'b0;
        slv_ar       = '0;
        slv_aw       = '0;
        slv_w        = '0;
        slv_ar_valid = 1'b0;
        slv_aw_valid = 1'b0;
        slv_w_valid  = 1'b0;
        mst_ar_ready = 1'b1;
        mst_aw_ready = 1'b1;
        mst_w_ready  = 1'b1;
        wait (rst_n);
        @(posedge clk);
        #1;

        begin_test("plain read");
        check_value("slv_r_valid_o", slv_r_valid, 0);
        check_value("slv_b_valid_o", slv_b_valid, 0);
        check_value("mst_aw_valid_o", mst_aw_valid, 0);
        send_read(32'h0000_0200, 2'd3, 1'b0, `LRSC_RESP_OKAY);
        // Lock outside the range is not exclusive
        send_read(32'h0000_0240, 2'd2, 1'b1, `LRSC_RESP_OKAY);
        wait_responses();
        end_test();

        begin_test("exclusive pair");
        send_read(32'h0000_1040, 2'd1, 1'b1, `LRSC_RESP_EXOKAY);
        send_write(32'h0000_1040, 2'd1, 1'b1, 32'h1234_5678, `LRSC_RESP_EXOKAY);
        wait_responses();
        check_value("mst_aw_valid_o transfers", aw_count, aw_before + 1);
        check_value("mst_w_valid_o transfers", w_count, w_before + 1);
        check_value("mst_aw_o.addr", slave_aw.addr, 32'h0000_1040);
        check_value("mst_w_o.data", last_w_data, 32'h1234_5678);
        check_value("mst_w_o.strb", last_w_strb, 4'hF);
        end_test();

        begin_test("exclusive write without reservation");
        send_write(32'h0000_1080, 2'd2, 1'b1, 32'hDEAD_BEEF, `LRSC_RESP_OKAY);
        wait_responses();
        check_value("mst_aw_valid_o transfers", aw_count, aw_before);
        check_value("mst_w_valid_o transfers", w_count, w_before);
        end_test();

        begin_test("reservation lost to other id");
        send_read(32'h0000_10C0, 2'd0, 1'b1, `LRSC_RESP_EXOKAY);
        send_write(32'h0000_10C0, 2'd1, 1'b0, 32'h0000_0001, `LRSC_RESP_OKAY);
        wait_responses();
        aw_before = aw_count;
        w_before  = w_count;
        send_write(32'h0000_10C0, 2'd0, 1'b1, 32'h0000_0002, `LRSC_RESP_OKAY);
        wait_responses();
        check_value("mst_aw_valid_o transfers", aw_count, aw_before);
        check_value("mst_w_valid_o transfers", w_count, w_before);
        end_test();

        begin_test("error passthrough");
        send_read(SLVERR_ADDR, 2'd3, 1'b1, `LRSC_RESP_SLVERR);
        send_write(SLVERR_ADDR, 2'd3, 1'b1, 32'hCAFE_0000, `LRSC_RESP_SLVERR);
        wait_responses();
        end_test();

        begin_test("back-pressure ordering");
        stall_ready = 1'b1;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    send_read(32'h0000_0300 + 4 * i, i % 4, 1'b0, `LRSC_RESP_OKAY);
                end
            end
            begin
                for (int j = 0; j < 8; j++) begin
                    send_write(32'h0000_1100 + 4 * j, (j + 1) % 4, 1'b0, j,
                               `LRSC_RESP_OKAY);
                end
            end
        join
        wait_responses();
        stall_ready = 1'b0;
        end_test();

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/lrsc_axi_pkg.sv
logic/lrsc_res_pkg.sv
logic/lrsc_resp_reg.sv
logic/lrsc_res_table.sv
logic/lrsc_read_path.sv
logic/lrsc_write_path.sv
logic/axi_lrsc.sv
tb/tb_clk_gen.sv
tb/tb_axi_lrsc.sv
